//--- logic/isaPkg.sv
package isaPkg;

	localparam int instrWidth = 32;    // Instruction word
	localparam int regAddrWidth = 5;   // 32 registers

	localparam logic [regAddrWidth-1:0] linkReg = 5'd30;  // X30, BL return address
	localparam logic [regAddrWidth-1:0] zeroReg = 5'd31;  // XZR

	// Field positions in the instruction word
	localparam int opcodeLsb = 21;     // 11-bit opcode at the top
	localparam int rdLsb = 0;
	localparam int rtLsb = 0;          // Same slot as Rd
	localparam int rnLsb = 5;
	localparam int rmLsb = 16;
	localparam int shamtLsb = 10;
	localparam int shamtWidth = 6;
	localparam int imm12Lsb = 10;
	localparam int imm12Width = 12;
	localparam int imm9Lsb = 12;
	localparam int imm9Width = 9;
	localparam int imm19Lsb = 5;       // CB and B.cond offset
	localparam int imm19Width = 19;
	localparam int imm26Lsb = 0;       // B and BL offset
	localparam int imm26Width = 26;
	localparam int condLsb = 0;
	localparam int condWidth = 4;

	typedef enum logic [4:0] {
		opAdd, opAdds, opSub, opSubs,
		opAnd, opAnds, opOrr, opEor,
		opAddi, opAddis, opSubi, opSubis,
		opAndi, opOrri, opEori,
		opLsl, opLsr,
		opLdur, opStur,
		opB, opBCond, opCbz, opCbnz, opBl, opBr,
		opNop                          // Anything not recognized
	} opcode_e;

	typedef enum logic [3:0] {
		condEq = 4'h0,
		condNe = 4'h1,
		condHs = 4'h2,
		condLo = 4'h3,
		condMi = 4'h4,
		condPl = 4'h5,
		condVs = 4'h6,
		condVc = 4'h7,
		condHi = 4'h8,
		condLs = 4'h9,
		condGe = 4'ha,
		condLt = 4'hb,
		condGt = 4'hc,
		condLe = 4'hd,
		condAl = 4'he,
		condNv = 4'hf                  // Behaves as always
	} cond_e;

	typedef enum logic [1:0] {
		brNone,                        // Step not flag dependent
		brCond,                        // B.cond, condition code on flags
		brZero,                        // CBZ
		brNonZero                      // CBNZ
	} branchKind_e;

endpackage

//--- logic/ctrlPkg.sv
package ctrlPkg;

	localparam int stepWidth = 2;      // Holds a step count of 1 or 2

	// ALU function select, bit 0 inverts B
	typedef enum logic [4:0] {
		fnAnd = 5'b00000,
		fnOr = 5'b00100,
		fnXor = 5'b01100,
		fnAdd = 5'b01000,
		fnSub = 5'b01001,
		fnShl = 5'b10000,
		fnShr = 5'b10100
	} funcSel_e;

	typedef enum logic [1:0] {
		pcHold,
		pcIncrement,
		pcRegister,                    // PC from register A
		pcOffset                       // PC plus K
	} pcFunc_e;

	typedef enum logic [1:0] {
		dsAlu,
		dsMemory,
		dsPcLink,                      // PC onto the data bus for BL
		dsFetch                        // Instruction memory into IR
	} dataSel_e;

	typedef enum logic [1:0] {
		stReset,                       // Idle cycle after reset
		stFetch,
		stStep0,
		stStep1
	} seqState_e;

	// Fetch word, all other fields zero
	localparam logic fetchLoadIr = 1'b1;
	localparam logic fetchAddrSelect = 1'b1;           // Address from PC
	localparam dataSel_e fetchDataSelect = dsFetch;
	localparam pcFunc_e fetchPcFunc = pcIncrement;

	// No-op word only advances the PC
	localparam pcFunc_e nopPcFunc = pcIncrement;

endpackage

//--- logic/condEval.sv
`timescale 1ns/1ps

module condEval (
	input isaPkg::branchKind_e branchKind,
	input isaPkg::cond_e condCode,
	input logic [3:0] status,          // V, C, N, Z
	output logic branchTaken
);

	logic flagV, flagC, flagN, flagZ;
	logic condMet;

	assign {flagV, flagC, flagN, flagZ} = status;

	always_comb begin
		case (condCode)
			isaPkg::condEq: condMet = flagZ;
			isaPkg::condNe: condMet = !flagZ;
			isaPkg::condHs: condMet = flagC;
			isaPkg::condLo: condMet = !flagC;
			isaPkg::condMi: condMet = flagN;
			isaPkg::condPl: condMet = !flagN;
			isaPkg::condVs: condMet = flagV;
			isaPkg::condVc: condMet = !flagV;
			isaPkg::condHi: condMet = flagC && !flagZ;       // Unsigned higher
			isaPkg::condLs: condMet = !flagC || flagZ;
			isaPkg::condGe: condMet = (flagN == flagV);      // Signed compare
			isaPkg::condLt: condMet = (flagN != flagV);
			isaPkg::condGt: condMet = !flagZ && (flagN == flagV);
			isaPkg::condLe: condMet = flagZ || (flagN != flagV);
			default: condMet = 1'b1;                         // AL and NV
		endcase
	end

	always_comb begin
		case (branchKind)
			isaPkg::brCond: branchTaken = condMet;
			isaPkg::brZero: branchTaken = flagZ;
			isaPkg::brNonZero: branchTaken = !flagZ;
			default: branchTaken = 1'b1;                     // Unconditional step
		endcase
	end

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
	parameter int dataWidth = 64       // Width of K
) (
	input logic [isaPkg::instrWidth-1:0] instr,
	output logic [ctrlPkg::stepWidth-1:0] stepCount,
	output isaPkg::branchKind_e branchKind,
	output isaPkg::cond_e condCode,
	output logic s0RegWrite,
	output logic [isaPkg::regAddrWidth-1:0] s0AddrA,
	output logic [isaPkg::regAddrWidth-1:0] s0AddrB,
	output logic [isaPkg::regAddrWidth-1:0] s0AddrD,
	output logic [dataWidth-1:0] s0ConstK,
	output ctrlPkg::funcSel_e s0FuncSel,
	output logic s0BSelect,
	output logic s0CarryIn,
	output logic s0LoadStatus,
	output logic s0RamWrite,
	output logic s0PcSelect,
	output ctrlPkg::pcFunc_e s0PcFunc,
	output ctrlPkg::dataSel_e s0DataSelect,
	output logic s1RegWrite,
	output logic [isaPkg::regAddrWidth-1:0] s1AddrA,
	output logic [isaPkg::regAddrWidth-1:0] s1AddrB,
	output logic [isaPkg::regAddrWidth-1:0] s1AddrD,
	output logic [dataWidth-1:0] s1ConstK,
	output ctrlPkg::funcSel_e s1FuncSel,
	output logic s1BSelect,
	output logic s1CarryIn,
	output logic s1LoadStatus,
	output logic s1RamWrite,
	output logic s1PcSelect,
	output ctrlPkg::pcFunc_e s1PcFunc,
	output ctrlPkg::dataSel_e s1DataSelect
);

	isaPkg::opcode_e opcode;
	logic [isaPkg::instrWidth-1:isaPkg::opcodeLsb] opField;
	logic [isaPkg::regAddrWidth-1:0] rd, rt, rn, rm;
	logic [dataWidth-1:0] imm12Ext, imm9Ext, shamtExt, imm19Ext, imm26Ext, brOffset;
	logic isRegAlu, isImm, isShift, isSub, setFlags;
	ctrlPkg::funcSel_e aluFunc;

	assign opField = instr[isaPkg::instrWidth-1:isaPkg::opcodeLsb];
	assign rd = instr[isaPkg::rdLsb +: isaPkg::regAddrWidth];
	assign rt = instr[isaPkg::rtLsb +: isaPkg::regAddrWidth];
	assign rn = instr[isaPkg::rnLsb +: isaPkg::regAddrWidth];
	assign rm = instr[isaPkg::rmLsb +: isaPkg::regAddrWidth];
	assign condCode = isaPkg::cond_e'(instr[isaPkg::condLsb +: isaPkg::condWidth]);

	// Immediates zero-extended, branch offsets sign-extended
	assign imm12Ext = {{(dataWidth-isaPkg::imm12Width){1'b0}},
		instr[isaPkg::imm12Lsb +: isaPkg::imm12Width]};
	assign imm9Ext = {{(dataWidth-isaPkg::imm9Width){1'b0}},
		instr[isaPkg::imm9Lsb +: isaPkg::imm9Width]};
	assign shamtExt = {{(dataWidth-isaPkg::shamtWidth){1'b0}},
		instr[isaPkg::shamtLsb +: isaPkg::shamtWidth]};
	assign imm19Ext = {{(dataWidth-isaPkg::imm19Width){instr[isaPkg::imm19Lsb+isaPkg::imm19Width-1]}},
		instr[isaPkg::imm19Lsb +: isaPkg::imm19Width]};
	assign imm26Ext = {{(dataWidth-isaPkg::imm26Width){instr[isaPkg::imm26Lsb+isaPkg::imm26Width-1]}},
		instr[isaPkg::imm26Lsb +: isaPkg::imm26Width]};
	assign brOffset = (opcode inside {isaPkg::opB, isaPkg::opBl}) ? imm26Ext : imm19Ext;

	always_comb begin
		casez (opField)
			11'b10001011000: opcode = isaPkg::opAdd;
			11'b10101011000: opcode = isaPkg::opAdds;
			11'b11001011000: opcode = isaPkg::opSub;
			11'b11101011000: opcode = isaPkg::opSubs;
			11'b10001010000: opcode = isaPkg::opAnd;
			11'b11101010000: opcode = isaPkg::opAnds;
			11'b10101010000: opcode = isaPkg::opOrr;
			11'b11001010000: opcode = isaPkg::opEor;
			11'b1001000100?: opcode = isaPkg::opAddi;   // I-format, 10-bit opcode
			11'b1011000100?: opcode = isaPkg::opAddis;
			11'b1101000100?: opcode = isaPkg::opSubi;
			11'b1111000100?: opcode = isaPkg::opSubis;
			11'b1001001000?: opcode = isaPkg::opAndi;
			11'b1011001000?: opcode = isaPkg::opOrri;
			11'b1101001000?: opcode = isaPkg::opEori;
			11'b11010011011: opcode = isaPkg::opLsl;
			11'b11010011010: opcode = isaPkg::opLsr;
			11'b11111000010: opcode = isaPkg::opLdur;
			11'b11111000000: opcode = isaPkg::opStur;
			11'b11010110000: opcode = isaPkg::opBr;
			11'b000101?????: opcode = isaPkg::opB;      // B-format, 6-bit opcode
			11'b100101?????: opcode = isaPkg::opBl;
			11'b01010100???: opcode = isaPkg::opBCond;  // CB-format, 8-bit opcode
			11'b10110100???: opcode = isaPkg::opCbz;
			11'b10110101???: opcode = isaPkg::opCbnz;
			default: opcode = isaPkg::opNop;
		endcase
	end

	assign isRegAlu = opcode inside {isaPkg::opAdd, isaPkg::opAdds, isaPkg::opSub,
		isaPkg::opSubs, isaPkg::opAnd, isaPkg::opAnds, isaPkg::opOrr, isaPkg::opEor};
	assign isImm = opcode inside {isaPkg::opAddi, isaPkg::opAddis, isaPkg::opSubi,
		isaPkg::opSubis, isaPkg::opAndi, isaPkg::opOrri, isaPkg::opEori};
	assign isShift = opcode inside {isaPkg::opLsl, isaPkg::opLsr};
	assign isSub = opcode inside {isaPkg::opSub, isaPkg::opSubs, isaPkg::opSubi, isaPkg::opSubis};
	assign setFlags = opcode inside {isaPkg::opAdds, isaPkg::opSubs, isaPkg::opAnds,
		isaPkg::opAddis, isaPkg::opSubis};

	always_comb begin
		case (opcode)
			isaPkg::opSub, isaPkg::opSubs, isaPkg::opSubi, isaPkg::opSubis: aluFunc = ctrlPkg::fnSub;
			isaPkg::opAnd, isaPkg::opAnds, isaPkg::opAndi: aluFunc = ctrlPkg::fnAnd;
			isaPkg::opOrr, isaPkg::opOrri: aluFunc = ctrlPkg::fnOr;
			isaPkg::opEor, isaPkg::opEori: aluFunc = ctrlPkg::fnXor;
			isaPkg::opLsl: aluFunc = ctrlPkg::fnShl;
			isaPkg::opLsr: aluFunc = ctrlPkg::fnShr;
			default: aluFunc = ctrlPkg::fnAdd;               // Adds and address calc
		endcase
	end

	assign stepCount = (opcode inside {isaPkg::opLdur, isaPkg::opStur, isaPkg::opCbz,
		isaPkg::opCbnz, isaPkg::opBl}) ? 2'd2 : 2'd1;

	always_comb begin
		case (opcode)
			isaPkg::opBCond: branchKind = isaPkg::brCond;    // Decides step 0
			isaPkg::opCbz: branchKind = isaPkg::brZero;      // Decides step 1
			isaPkg::opCbnz: branchKind = isaPkg::brNonZero;
			default: branchKind = isaPkg::brNone;
		endcase
	end

	always_comb begin
		// Both steps start as the no-op word
		s0RegWrite = 1'b0;
		s0AddrA = '0;
		s0AddrB = '0;
		s0AddrD = '0;
		s0ConstK = '0;
		s0FuncSel = ctrlPkg::fnAnd;
		s0BSelect = 1'b0;
		s0CarryIn = 1'b0;
		s0LoadStatus = 1'b0;
		s0RamWrite = 1'b0;
		s0PcSelect = 1'b0;
		s0PcFunc = ctrlPkg::nopPcFunc;
		s0DataSelect = ctrlPkg::dsAlu;
		s1RegWrite = 1'b0;
		s1AddrA = '0;
		s1AddrB = '0;
		s1AddrD = '0;
		s1ConstK = '0;
		s1FuncSel = ctrlPkg::fnAnd;
		s1BSelect = 1'b0;
		s1CarryIn = 1'b0;
		s1LoadStatus = 1'b0;
		s1RamWrite = 1'b0;
		s1PcSelect = 1'b0;
		s1PcFunc = ctrlPkg::nopPcFunc;
		s1DataSelect = ctrlPkg::dsAlu;

		if (isRegAlu || isImm || isShift) begin
			s0RegWrite = 1'b1;
			s0AddrA = rn;
			s0AddrB = isImm ? '0 : rm;                       // Rm slot is immediate bits
			s0AddrD = rd;
			s0ConstK = isImm ? imm12Ext : (isShift ? shamtExt : '0);
			s0FuncSel = aluFunc;
			s0BSelect = isImm || isShift;                    // K as B operand
			s0CarryIn = isSub;                               // Two's complement of B
			s0LoadStatus = setFlags;
		end

		case (opcode)
			isaPkg::opLdur, isaPkg::opStur: begin
				s0RegWrite = (opcode == isaPkg::opLdur);
				s0AddrA = rn;                                // Base register
				s0AddrB = (opcode == isaPkg::opStur) ? rt : '0;  // Store data
				s0AddrD = (opcode == isaPkg::opLdur) ? rt : '0;
				s0ConstK = imm9Ext;
				s0FuncSel = ctrlPkg::fnAdd;
				s0BSelect = 1'b1;
				s0RamWrite = (opcode == isaPkg::opStur);
				s0PcFunc = ctrlPkg::pcHold;
				s0DataSelect = (opcode == isaPkg::opLdur) ? ctrlPkg::dsMemory : ctrlPkg::dsAlu;
			end
			isaPkg::opB, isaPkg::opBCond: begin
				s0PcSelect = 1'b1;
				s0PcFunc = ctrlPkg::pcOffset;
				s0ConstK = brOffset;
			end
			isaPkg::opBr: begin
				s0AddrA = rn;
				s0PcFunc = ctrlPkg::pcRegister;
			end
			isaPkg::opCbz, isaPkg::opCbnz: begin
				s0AddrA = rt;                                // Rt minus XZR sets Z
				s0AddrB = isaPkg::zeroReg;
				s0FuncSel = ctrlPkg::fnSub;
				s0CarryIn = 1'b1;
				s0PcFunc = ctrlPkg::pcHold;
			end
			isaPkg::opBl: begin
				s0RegWrite = 1'b1;
				s0AddrD = isaPkg::linkReg;
				s0PcFunc = ctrlPkg::pcHold;
				s0DataSelect = ctrlPkg::dsPcLink;            // Return address into X30
			end
			default: begin
			end
		endcase

		if (opcode inside {isaPkg::opLdur, isaPkg::opStur}) begin
			// Second memory cycle repeats step 0, then moves on
			s1RegWrite = s0RegWrite;
			s1AddrA = s0AddrA;
			s1AddrB = s0AddrB;
			s1AddrD = s0AddrD;
			s1ConstK = s0ConstK;
			s1FuncSel = s0FuncSel;
			s1BSelect = s0BSelect;
			s1DataSelect = s0DataSelect;
			s1PcFunc = ctrlPkg::pcIncrement;
		end else if (opcode inside {isaPkg::opBl, isaPkg::opCbz, isaPkg::opCbnz}) begin
			s1PcSelect = 1'b1;                               // Branch word
			s1PcFunc = ctrlPkg::pcOffset;
			s1ConstK = brOffset;
		end
	end

endmodule

//--- logic/microSequencer.sv
`timescale 1ns/1ps

module microSequencer #(
	parameter int dataWidth = 64
) (
	input logic clock,
	input logic rstN,
	input logic [3:0] status,
	input logic [ctrlPkg::stepWidth-1:0] stepCount,
	input isaPkg::branchKind_e branchKind,
	input isaPkg::cond_e condCode,
	input logic s0RegWrite,
	input logic [isaPkg::regAddrWidth-1:0] s0AddrA,
	input logic [isaPkg::regAddrWidth-1:0] s0AddrB,
	input logic [isaPkg::regAddrWidth-1:0] s0AddrD,
	input logic [dataWidth-1:0] s0ConstK,
	input ctrlPkg::funcSel_e s0FuncSel,
	input logic s0BSelect,
	input logic s0CarryIn,
	input logic s0LoadStatus,
	input logic s0RamWrite,
	input logic s0PcSelect,
	input ctrlPkg::pcFunc_e s0PcFunc,
	input ctrlPkg::dataSel_e s0DataSelect,
	input logic s1RegWrite,
	input logic [isaPkg::regAddrWidth-1:0] s1AddrA,
	input logic [isaPkg::regAddrWidth-1:0] s1AddrB,
	input logic [isaPkg::regAddrWidth-1:0] s1AddrD,
	input logic [dataWidth-1:0] s1ConstK,
	input ctrlPkg::funcSel_e s1FuncSel,
	input logic s1BSelect,
	input logic s1CarryIn,
	input logic s1LoadStatus,
	input logic s1RamWrite,
	input logic s1PcSelect,
	input ctrlPkg::pcFunc_e s1PcFunc,
	input ctrlPkg::dataSel_e s1DataSelect,
	output logic regWrite,
	output logic [isaPkg::regAddrWidth-1:0] addrA,
	output logic [isaPkg::regAddrWidth-1:0] addrB,
	output logic [isaPkg::regAddrWidth-1:0] addrD,
	output logic [dataWidth-1:0] constK,
	output ctrlPkg::funcSel_e funcSel,
	output logic bSelect,
	output logic carryIn,
	output logic loadStatus,
	output logic ramWrite,
	output logic pcSelect,
	output ctrlPkg::pcFunc_e pcFunc,
	output logic loadIr,
	output logic addrSelect,
	output ctrlPkg::dataSel_e dataSelect
);

	ctrlPkg::seqState_e state, nextState;
	logic branchTaken;
	logic stepSel;                     // Step 1 word selected
	logic loadStep;                    // Step word goes out, else no-op

	condEval condEval_inst (
		.branchKind(branchKind),
		.condCode(condCode),
		.status(status),
		.branchTaken(branchTaken)
	);

	// Only a one-step branch is gated in step 0, step 1 always follows the flags
	assign stepSel = (state == ctrlPkg::stStep1);
	assign loadStep = ((state == ctrlPkg::stStep0) && (stepCount == 2'd2 || branchTaken)) ||
		(stepSel && branchTaken);

	always_comb begin
		case (state)
			ctrlPkg::stReset: nextState = ctrlPkg::stFetch;
			ctrlPkg::stFetch: nextState = ctrlPkg::stStep0;
			ctrlPkg::stStep0: nextState = (stepCount == 2'd2) ? ctrlPkg::stStep1 : ctrlPkg::stFetch;
			default: nextState = ctrlPkg::stFetch;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= ctrlPkg::stReset;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clock) begin
		// All-zero word in reset and the idle cycle
		regWrite <= 1'b0;
		addrA <= '0;
		addrB <= '0;
		addrD <= '0;
		constK <= '0;
		funcSel <= ctrlPkg::fnAnd;
		bSelect <= 1'b0;
		carryIn <= 1'b0;
		loadStatus <= 1'b0;
		ramWrite <= 1'b0;
		pcSelect <= 1'b0;
		pcFunc <= ctrlPkg::pcHold;
		loadIr <= 1'b0;
		addrSelect <= 1'b0;
		dataSelect <= ctrlPkg::dsAlu;
		if (rstN) begin
			if (state == ctrlPkg::stFetch) begin
				loadIr <= ctrlPkg::fetchLoadIr;
				addrSelect <= ctrlPkg::fetchAddrSelect;
				dataSelect <= ctrlPkg::fetchDataSelect;
				pcFunc <= ctrlPkg::fetchPcFunc;
			end else if (loadStep) begin
				regWrite <= stepSel ? s1RegWrite : s0RegWrite;
				addrA <= stepSel ? s1AddrA : s0AddrA;
				addrB <= stepSel ? s1AddrB : s0AddrB;
				addrD <= stepSel ? s1AddrD : s0AddrD;
				constK <= stepSel ? s1ConstK : s0ConstK;
				funcSel <= stepSel ? s1FuncSel : s0FuncSel;
				bSelect <= stepSel ? s1BSelect : s0BSelect;
				carryIn <= stepSel ? s1CarryIn : s0CarryIn;
				loadStatus <= stepSel ? s1LoadStatus : s0LoadStatus;
				ramWrite <= stepSel ? s1RamWrite : s0RamWrite;
				pcSelect <= stepSel ? s1PcSelect : s0PcSelect;
				pcFunc <= stepSel ? s1PcFunc : s0PcFunc;
				dataSelect <= stepSel ? s1DataSelect : s0DataSelect;
			end else if (state != ctrlPkg::stReset) begin
				pcFunc <= ctrlPkg::nopPcFunc;                // Branch not taken
			end
		end
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter int dataWidth = 64       // Datapath width, also runs at 32
) (
	input logic clock,
	input logic rstN,
	input logic [isaPkg::instrWidth-1:0] instr,
	input logic [3:0] status,          // V, C, N, Z from the datapath
	output logic regWrite,
	output logic [isaPkg::regAddrWidth-1:0] addrA,
	output logic [isaPkg::regAddrWidth-1:0] addrB,
	output logic [isaPkg::regAddrWidth-1:0] addrD,
	output logic [dataWidth-1:0] constK,
	output ctrlPkg::funcSel_e funcSel,
	output logic bSelect,
	output logic carryIn,
	output logic loadStatus,
	output logic ramWrite,
	output logic pcSelect,
	output ctrlPkg::pcFunc_e pcFunc,
	output logic loadIr,
	output logic addrSelect,
	output ctrlPkg::dataSel_e dataSelect
);

	// Decoder to sequencer, connected by name
	logic [ctrlPkg::stepWidth-1:0] stepCount;
	isaPkg::branchKind_e branchKind;
	isaPkg::cond_e condCode;
	logic s0RegWrite, s0BSelect, s0CarryIn, s0LoadStatus, s0RamWrite, s0PcSelect;
	logic s1RegWrite, s1BSelect, s1CarryIn, s1LoadStatus, s1RamWrite, s1PcSelect;
	logic [isaPkg::regAddrWidth-1:0] s0AddrA, s0AddrB, s0AddrD;
	logic [isaPkg::regAddrWidth-1:0] s1AddrA, s1AddrB, s1AddrD;
	logic [dataWidth-1:0] s0ConstK, s1ConstK;
	ctrlPkg::funcSel_e s0FuncSel, s1FuncSel;
	ctrlPkg::pcFunc_e s0PcFunc, s1PcFunc;
	ctrlPkg::dataSel_e s0DataSelect, s1DataSelect;

	instrDecoder #(.dataWidth(dataWidth)) instrDecoder_inst (.*);

	microSequencer #(.dataWidth(dataWidth)) microSequencer_inst (.*);

endmodule

//--- tests/controlUnit_asserts.sv
`timescale 1ns/1ps

module controlUnit_asserts #(
	parameter int dataWidth = 64
) (
	input logic clock,
	input logic rstN,
	input logic regWrite,
	input logic [4:0] addrA,
	input logic [4:0] addrB,
	input logic [4:0] addrD,
	input logic [dataWidth-1:0] constK,
	input ctrlPkg::funcSel_e funcSel,
	input logic bSelect,
	input logic carryIn,
	input logic loadStatus,
	input logic ramWrite,
	input logic pcSelect,
	input ctrlPkg::pcFunc_e pcFunc,
	input logic loadIr,
	input logic addrSelect,
	input ctrlPkg::dataSel_e dataSelect
);

	logic [31:0] allFields;            // Every output except K
	int failCount = 0;                 // Assertion failures so far

	assign allFields = {regWrite, addrA, addrB, addrD, funcSel, bSelect, carryIn,
		loadStatus, ramWrite, pcSelect, pcFunc, loadIr, addrSelect, dataSelect};

	// Fetch lasts exactly one cycle
	assert property (@(posedge clock) disable iff (!rstN) loadIr |=> !loadIr)
		else begin
			$error("loadIr high on two consecutive cycles");
			failCount++;
		end

	assert property (@(posedge clock) disable iff (!rstN) !(ramWrite && regWrite))
		else begin
			$error("ramWrite and regWrite high together");
			failCount++;
		end

	// Outputs are registered so the cleared word shows one edge later
	assert property (@(posedge clock) !rstN |=> (allFields == '0 && constK == '0))
		else begin
			$error("control outputs not cleared by reset");
			failCount++;
		end

endmodule

bind microSequencer controlUnit_asserts #(.dataWidth(dataWidth)) asserts_inst (.*);

//--- tests/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	localparam int dataWidth = 64;
	localparam int fetchLimit = 8;      // Cycles allowed until a fetch word

	logic clock;
	logic rstN;
	logic [31:0] instr;
	logic [3:0] status;                 // V, C, N, Z
	logic regWrite;
	logic [4:0] addrA, addrB, addrD;
	logic [dataWidth-1:0] constK;
	ctrlPkg::funcSel_e funcSel;
	logic bSelect, carryIn, loadStatus, ramWrite, pcSelect;
	ctrlPkg::pcFunc_e pcFunc;
	logic loadIr, addrSelect;
	ctrlPkg::dataSel_e dataSelect;
	int assertFails;                    // Failures seen by the bound checker

	// Current line of the data file
	string testName;
	logic [31:0] testInstr;
	logic [3:0] fetchStatus, stepStatus;
	int numSteps;
	logic [63:0] expRegWrite[2], expAddrD[2], expConstK[2], expFuncSel[2];
	logic [63:0] expPcFunc[2], expRamWrite[2], expDataSelect[2];

	controlUnit #(.dataWidth(dataWidth)) controlUnit_inst (.*);

	assign assertFails = controlUnit_inst.microSequencer_inst.asserts_inst.failCount;

	initial clock = 1'b0;
	always #20 clock = ~clock;          // 40 ns period

	// All outputs but K packed into one word
	function automatic logic [31:0] controlWord();
		return {regWrite, addrA, addrB, addrD, funcSel, bSelect, carryIn, loadStatus,
			ramWrite, pcSelect, pcFunc, loadIr, addrSelect, dataSelect};
	endfunction

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkEqual(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			stopRun($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
				what, expected, actual));
		end
	endtask

	always @(assertFails) begin
		if (assertFails != 0) begin
			stopRun("An assertion on the sequencer failed");
		end
	end

	// Sampled 2 ns after each edge when outputs have settled
	task automatic waitForFetch(output int cycles);
		cycles = 0;
		do begin
			@(posedge clock);
			#2;
			cycles++;
		end while (loadIr !== 1'b1 && cycles < fetchLimit);
		if (loadIr !== 1'b1) begin
			stopRun($sformatf("No fetch word appeared within %0d cycles", cycles));
		end
	endtask

	task automatic checkStep(input int s);
		string tag;
		tag = $sformatf("%s step%0d", testName, s);
		checkEqual({tag, " regWrite"}, expRegWrite[s], regWrite);
		checkEqual({tag, " addrD"}, expAddrD[s], addrD);
		checkEqual({tag, " constK"}, expConstK[s], constK);
		checkEqual({tag, " funcSel"}, expFuncSel[s], funcSel);
		checkEqual({tag, " pcFunc"}, expPcFunc[s], pcFunc);
		checkEqual({tag, " ramWrite"}, expRamWrite[s], ramWrite);
		checkEqual({tag, " dataSelect"}, expDataSelect[s], dataSelect);
	endtask

	// Entered in the fetch cycle and left in the next one
	task automatic runCase();
		int cycles;
		checkEqual({testName, " fetch word"}, {26'd0, 2'd1, 1'b1, 1'b1, 2'd3}, controlWord());
		checkEqual({testName, " fetch constK"}, 0, constK);
		instr = testInstr;                // Held until the next fetch
		status = fetchStatus;             // Seen by B.cond at the edge ending fetch
		@(posedge clock);
		#2;
		status = stepStatus;              // Seen by CBZ and CBNZ at the end of step 0
		checkStep(0);
		if (numSteps == 2) begin
			@(posedge clock);
			#2;
			checkStep(1);
		end
		waitForFetch(cycles);
		checkEqual({testName, " cycles from last step to fetch"}, 1, cycles);
	endtask

	initial begin
		int fd;
		int fields;
		int cycles;
		int caseCount;
		string line;
		rstN = 1'b0;
		instr = '0;
		status = '0;
		caseCount = 0;
		fd = $fopen("tests/controlUnitTests.txt", "r");
		if (fd == 0) begin
			stopRun("Could not open tests/controlUnitTests.txt");
		end
		repeat (4) begin
			@(posedge clock);
			#2;
			checkEqual("reset control word", 0, controlWord());
			checkEqual("reset constK", 0, constK);
		end
		rstN = 1'b1;
		@(posedge clock);
		#2;
		checkEqual("idle control word", 0, controlWord());   // Idle cycle after release
		checkEqual("idle constK", 0, constK);
		waitForFetch(cycles);
		checkEqual("cycles from idle to fetch", 1, cycles);
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;                     // Blank or comment
			end
			fields = $sscanf(line, "%s %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				testName, testInstr, fetchStatus, stepStatus, numSteps,
				expRegWrite[0], expAddrD[0], expConstK[0], expFuncSel[0],
				expPcFunc[0], expRamWrite[0], expDataSelect[0],
				expRegWrite[1], expAddrD[1], expConstK[1], expFuncSel[1],
				expPcFunc[1], expRamWrite[1], expDataSelect[1]);
			if (fields != 19 || numSteps < 1 || numSteps > 2) begin
				stopRun({"Malformed line in the test data file: ", line});
			end
			caseCount++;
			runCase();
		end
		$fclose(fd);
		if (caseCount == 0) begin
			stopRun("The test data file held no cases");
		end else if (assertFails != 0) begin
			stopRun("An assertion on the sequencer failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- sim.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/condEval.sv
logic/instrDecoder.sv
logic/microSequencer.sv
logic/controlUnit.sv
tests/controlUnit_asserts.sv
tests/controlUnitTb.sv

//--- tests/controlUnitTests.txt
# name instr statusFetch statusStep0 steps, then per step: regWrite addrD constK funcSel pcFunc
# ramWrite dataSelect (step 0, then step 1); status is {V,C,N,Z}; all hex except steps
add       8b030041 0 0 1  1 01 0 08 1 0 0  0 00 0 00 0 0 0
subs      eb0600a4 0 0 1  1 04 0 09 1 0 0  0 00 0 00 0 0 0
ands      ea090107 0 0 1  1 07 0 00 1 0 0  0 00 0 00 0 0 0
orr       aa0c016a 0 0 1  1 0a 0 04 1 0 0  0 00 0 00 0 0 0
eor       ca0f01cd 0 0 1  1 0d 0 0c 1 0 0  0 00 0 00 0 0 0
addi      91048c43 0 0 1  1 03 123 08 1 0 0  0 00 0 00 0 0 0
subi      d13ffc85 0 0 1  1 05 fff 09 1 0 0  0 00 0 00 0 0 0
andi      9203c0c7 0 0 1  1 07 f0 00 1 0 0  0 00 0 00 0 0 0
eori      d2200429 0 0 1  1 09 801 0c 1 0 0  0 00 0 00 0 0 0
lsl       d3601441 0 0 1  1 01 5 10 1 0 0  0 00 0 00 0 0 0
lsr       d340fc62 0 0 1  1 02 3f 14 1 0 0  0 00 0 00 0 0 0
ldur      f85f0043 0 0 2  1 03 1f0 08 0 0 1  1 03 1f0 08 1 0 1
stur      f8010085 0 0 2  0 00 10 08 0 1 0  0 00 10 08 1 0 0
b         17fffffc 0 0 1  0 00 fffffffffffffffc 00 3 0 0  0 00 0 00 0 0 0
br        d60003c0 0 0 1  0 00 0 00 2 0 0  0 00 0 00 0 0 0
bl        94000010 0 0 2  1 1e 0 00 0 0 2  0 00 10 00 3 0 0
beq       54000100 1 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
beqNot    54000100 0 1 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bne       54000101 0 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bhs       54000102 4 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bloNot    54000103 4 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bmi       54000104 2 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bplNot    54000105 2 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bvs       54000106 8 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bvcNot    54000107 8 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bhi       54000108 4 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bhiNot    54000108 5 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bls       54000109 5 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bge       5400010a a 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bgeNot    5400010a 2 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
blt       5400010b 2 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bltNot    5400010b a 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
bgt       5400010c 0 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bgtNot    5400010c 1 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
ble       5400010d 8 0 1  0 00 8 00 3 0 0  0 00 0 00 0 0 0
bal       54ffffee 0 0 1  0 00 ffffffffffffffff 00 3 0 0  0 00 0 00 0 0 0
bnv       54ffffef f 0 1  0 00 ffffffffffffffff 00 3 0 0  0 00 0 00 0 0 0
cbz       b4000807 0 1 2  0 00 0 09 0 0 0  0 00 40 00 3 0 0
cbzNot    b4000807 1 0 2  0 00 0 09 0 0 0  0 00 0 00 1 0 0
cbnz      b5ffffc9 1 0 2  0 00 0 09 0 0 0  0 00 fffffffffffffffe 00 3 0 0
cbnzNot   b5ffffc9 0 1 2  0 00 0 09 0 0 0  0 00 0 00 1 0 0
unknown   00000000 0 0 1  0 00 0 00 1 0 0  0 00 0 00 0 0 0
